/* common/alu_config.svh */
// widths, opcodes and condition codes of the integer alu pipeline
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

`define ALU_DATA_W   64
`define ALU_OP_W     12
`define ALU_FLAGS_W  6   // C O A S Z P, msb first
`define ALU_OPC_W    6

`define ALU_OPC_ADD  6'h01
`define ALU_OPC_SUB  6'h02
`define ALU_OPC_AND  6'h03
`define ALU_OPC_OR   6'h04
`define ALU_OPC_XOR  6'h05
`define ALU_OPC_XNOR 6'h06
`define ALU_OPC_MOV  6'h07
`define ALU_OPC_ZXT  6'h08
`define ALU_OPC_SXT  6'h09
`define ALU_OPC_CMOV 6'h0a
`define ALU_OPC_CSET 6'h0b

// odd code is the inverse of the even one below it
`define COND_Z   4'd0
`define COND_NZ  4'd1
`define COND_S   4'd2
`define COND_NS  4'd3
`define COND_UGT 4'd4
`define COND_ULE 4'd5
`define COND_UGE 4'd6
`define COND_ULT 4'd7
`define COND_SGT 4'd8
`define COND_SLE 4'd9
`define COND_SGE 4'd10
`define COND_SLT 4'd11
`define COND_O   4'd12
`define COND_NO  4'd13
`define COND_P   4'd14
`define COND_NP  4'd15

`endif

/* common/alu_pkg.sv */
// shared types of the integer alu pipeline, operation word and stage words
`default_nettype none
`include "alu_config.svh"

package alu_pkg;

  typedef enum logic [1:0] {
    SZ_8  = 2'd0,
    SZ_16 = 2'd1,
    SZ_32 = 2'd2,
    SZ_64 = 2'd3
  } size_e;

  typedef enum logic [1:0] {
    LOGIC_AND  = 2'd0,
    LOGIC_OR   = 2'd1,
    LOGIC_XOR  = 2'd2,
    LOGIC_XNOR = 2'd3
  } logic_sel_e;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_s;

  // arithmetic, logic, move and extension ops
  typedef struct packed {
    logic [`ALU_OPC_W-1:0]            opcode;
    size_e                            dst_size;
    size_e                            src_size;
    logic [`ALU_OP_W-`ALU_OPC_W-5:0]  spare;
  } size_view_s;

  // cmov and cset
  typedef struct packed {
    logic [`ALU_OPC_W-1:0]            opcode;
    logic [3:0]                       cond;
    logic [`ALU_OP_W-`ALU_OPC_W-5:0]  spare;
  } cond_view_s;

  typedef union packed {
    size_view_s size_view;
    cond_view_s cond_view;
  } op_word_u;

  typedef struct packed {
    logic                   valid;
    op_word_u               op;
    logic [`ALU_DATA_W-1:0] a;
    logic [`ALU_DATA_W-1:0] b;
    flags_s                 flags_in;
  } alu_req_s;

  typedef struct packed {
    logic                   valid;
    logic                   is_add;
    logic                   is_sub;
    logic                   is_logic;
    logic                   is_move;
    logic                   is_ext;
    logic                   is_cmov;
    logic                   is_cset;
    logic_sel_e             logic_sel;
    size_e                  dst_size;
    size_e                  src_size;
    logic                   ext_signed;
    logic [3:0]             cond;
    logic [`ALU_DATA_W-1:0] a;
    logic [`ALU_DATA_W-1:0] b;
    flags_s                 flags_in;
    logic                   writes_flags;
  } dec_s;

  typedef struct packed {
    logic                   valid;
    logic [`ALU_DATA_W-1:0] result;
    logic                   carry;
    logic                   aux_carry;
    logic                   overflow;
    logic                   is_sub;
    size_e                  dst_size;
    logic                   writes_flags;
  } exe_s;

  typedef struct packed {
    logic                   valid;
    logic [`ALU_DATA_W-1:0] result;
    flags_s                 flags;
    logic                   flags_we;
  } alu_resp_s;

endpackage

`default_nettype wire

/* alu/cond_eval.sv */
// flag condition evaluator for cmov and cset, x86 style conditions
`timescale 1ns/10ps
`default_nettype none
`include "alu_config.svh"

module cond_eval
  import alu_pkg::*;
(
  input  flags_s           flags,
  input  wire logic [3:0]  cond,
  output logic             taken
);

  logic s_ne_o;

  assign s_ne_o = flags.s ^ flags.o;  // signed less than

  always_comb begin
    case (cond)
      `COND_Z:   taken = flags.z;
      `COND_NZ:  taken = ~flags.z;
      `COND_S:   taken = flags.s;
      `COND_NS:  taken = ~flags.s;
      `COND_UGT: taken = ~flags.c & ~flags.z;
      `COND_ULE: taken = flags.c | flags.z;
      `COND_UGE: taken = ~flags.c;
      `COND_ULT: taken = flags.c;
      `COND_SGT: taken = ~s_ne_o & ~flags.z;
      `COND_SLE: taken = s_ne_o | flags.z;
      `COND_SGE: taken = ~s_ne_o;
      `COND_SLT: taken = s_ne_o;
      `COND_O:   taken = flags.o;
      `COND_NO:  taken = ~flags.o;
      `COND_P:   taken = flags.p;
      default:   taken = ~flags.p;  // np
    endcase
  end

endmodule

`default_nettype wire

/* alu/alu_execute.sv */
// alu execute stage, result mux plus raw carry and overflow at operand size
`timescale 1ns/10ps
`default_nettype none
`include "alu_config.svh"

module alu_execute
  import alu_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  dec_s      dec,
  output exe_s      exe
);

  exe_s                   exe_d;
  logic [`ALU_DATA_W-1:0] bx;
  logic [`ALU_DATA_W:0]   sum;
  logic [`ALU_DATA_W-1:0] cin_vec;  // carry into each bit
  logic [`ALU_DATA_W-1:0] logic_res;
  logic [`ALU_DATA_W-1:0] ext_res;
  logic [`ALU_DATA_W-1:0] res;
  logic                   c_sz;
  logic                   ov_sz;
  logic                   arith;
  logic                   taken;

  cond_eval u_cond (
    .flags (dec.flags_in),
    .cond  (dec.cond),
    .taken (taken)
  );

  // one adder for both, sub is a + ~b + 1
  assign bx      = dec.is_sub ? ~dec.b : dec.b;
  assign sum     = {1'b0, dec.a} + {1'b0, bx} + {{`ALU_DATA_W{1'b0}}, dec.is_sub};
  assign cin_vec = dec.a ^ bx ^ sum[`ALU_DATA_W-1:0];
  assign arith   = dec.is_add | dec.is_sub;

  always_comb begin
    case (dec.dst_size)
      SZ_8:    c_sz = cin_vec[8];
      SZ_16:   c_sz = cin_vec[16];
      SZ_32:   c_sz = cin_vec[32];
      default: c_sz = sum[`ALU_DATA_W];
    endcase
    case (dec.dst_size)  // carry into sign bit vs carry out of it
      SZ_8:    ov_sz = cin_vec[7] ^ c_sz;
      SZ_16:   ov_sz = cin_vec[15] ^ c_sz;
      SZ_32:   ov_sz = cin_vec[31] ^ c_sz;
      default: ov_sz = cin_vec[`ALU_DATA_W-1] ^ c_sz;
    endcase
  end

  always_comb begin
    case (dec.logic_sel)
      LOGIC_AND:  logic_res = dec.a & dec.b;
      LOGIC_OR:   logic_res = dec.a | dec.b;
      LOGIC_XOR:  logic_res = dec.a ^ dec.b;
      default:    logic_res = ~(dec.a ^ dec.b);
    endcase
    case (dec.src_size)
      SZ_8:    ext_res = {{(`ALU_DATA_W-8){dec.ext_signed & dec.b[7]}}, dec.b[7:0]};
      SZ_16:   ext_res = {{(`ALU_DATA_W-16){dec.ext_signed & dec.b[15]}}, dec.b[15:0]};
      SZ_32:   ext_res = {{(`ALU_DATA_W-32){dec.ext_signed & dec.b[31]}}, dec.b[31:0]};
      default: ext_res = dec.b;
    endcase
  end

  always_comb begin
    res = '0;
    if (arith) res = sum[`ALU_DATA_W-1:0];
    else if (dec.is_logic) res = logic_res;
    else if (dec.is_move) res = dec.b;
    else if (dec.is_ext) res = ext_res;
    else if (dec.is_cmov) res = taken ? dec.b : dec.a;
    else if (dec.is_cset) res = {{(`ALU_DATA_W-1){1'b0}}, taken};
    if (dec.dst_size == SZ_32) res[`ALU_DATA_W-1:32] = '0;  // 32-bit writes clear upper half
  end

  always_comb begin
    exe_d.valid        = dec.valid;
    exe_d.result       = res;
    exe_d.carry        = arith & c_sz;
    exe_d.aux_carry    = arith & cin_vec[4];
    exe_d.overflow     = arith & ov_sz;
    exe_d.is_sub       = dec.is_sub;
    exe_d.dst_size     = dec.dst_size;
    exe_d.writes_flags = dec.writes_flags;
  end

  always_ff @(posedge clk) begin
    exe <= exe_d;
    if (rst) exe.valid <= 1'b0;
  end

endmodule

`default_nettype wire

/* source/op_decode.sv */
// alu decode stage that classifies the operation and latches the operands
`timescale 1ns/10ps
`default_nettype none
`include "alu_config.svh"

module op_decode
  import alu_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  alu_req_s  req,
  output dec_s      dec
);

  dec_s                  dec_d;
  logic [`ALU_OPC_W-1:0] opc;

  assign opc = req.op.size_view.opcode;  // same field in both views

  always_comb begin
    dec_d              = '0;
    dec_d.valid        = req.valid;
    dec_d.is_add       = (opc == `ALU_OPC_ADD);
    dec_d.is_sub       = (opc == `ALU_OPC_SUB);
    dec_d.is_logic     = opc inside {`ALU_OPC_AND, `ALU_OPC_OR, `ALU_OPC_XOR, `ALU_OPC_XNOR};
    dec_d.is_move      = (opc == `ALU_OPC_MOV);
    dec_d.is_ext       = (opc == `ALU_OPC_ZXT) || (opc == `ALU_OPC_SXT);
    dec_d.is_cmov      = (opc == `ALU_OPC_CMOV);
    dec_d.is_cset      = (opc == `ALU_OPC_CSET);
    dec_d.ext_signed   = (opc == `ALU_OPC_SXT);
    case (opc)
      `ALU_OPC_OR:   dec_d.logic_sel = LOGIC_OR;
      `ALU_OPC_XOR:  dec_d.logic_sel = LOGIC_XOR;
      `ALU_OPC_XNOR: dec_d.logic_sel = LOGIC_XNOR;
      default:       dec_d.logic_sel = LOGIC_AND;
    endcase
    if (dec_d.is_cmov || dec_d.is_cset) begin
      // low bits carry a condition code, op is always full width
      dec_d.cond     = req.op.cond_view.cond;
      dec_d.dst_size = SZ_64;
      dec_d.src_size = SZ_64;
    end else begin
      dec_d.dst_size = req.op.size_view.dst_size;
      dec_d.src_size = req.op.size_view.src_size;
    end
    dec_d.a            = req.a;
    dec_d.b            = req.b;
    dec_d.flags_in     = req.flags_in;
    dec_d.writes_flags = dec_d.is_add | dec_d.is_sub | dec_d.is_logic;
  end

  always_ff @(posedge clk) begin
    dec <= dec_d;
    if (rst) dec.valid <= 1'b0;
  end

endmodule

`default_nettype wire

/* source/flag_gen.sv */
// alu flag stage that builds the C O A S Z P word and registers the response
`timescale 1ns/10ps
`default_nettype none
`include "alu_config.svh"

module flag_gen
  import alu_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  exe_s      exe,
  output alu_resp_s resp
);

  alu_resp_s               resp_d;
  logic [`ALU_FLAGS_W-1:0] flags_d;
  logic                    sign;
  logic                    zero;

  always_comb begin
    case (exe.dst_size)
      SZ_8: begin
        sign = exe.result[7];
        zero = ~|exe.result[7:0];
      end
      SZ_16: begin
        sign = exe.result[15];
        zero = ~|exe.result[15:0];
      end
      SZ_32: begin
        sign = exe.result[31];
        zero = ~|exe.result[31:0];
      end
      default: begin
        sign = exe.result[`ALU_DATA_W-1];
        zero = ~|exe.result;
      end
    endcase
  end

  always_comb begin
    // borrow is the inverted adder carry on sub
    flags_d = {exe.carry ^ exe.is_sub,
               exe.overflow,
               exe.aux_carry ^ exe.is_sub,
               sign,
               zero,
               ~^exe.result[7:0]};
    if (!exe.writes_flags) flags_d = '0;
    resp_d.valid    = exe.valid;
    resp_d.result   = exe.result;
    resp_d.flags    = flags_d;
    resp_d.flags_we = exe.valid & exe.writes_flags;
  end

  always_ff @(posedge clk) begin
    resp <= resp_d;
    if (rst) begin
      resp.valid    <= 1'b0;
      resp.flags_we <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/alu_top.sv */
// integer alu top level, chains decode, execute and flag stages
`timescale 1ns/10ps
`default_nettype none

module alu_top
  import alu_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  alu_req_s  req,
  output alu_resp_s resp
);

  dec_s dec_w;  // decode -> execute
  exe_s exe_w;  // execute -> flags

  // stage 1
  op_decode u_decode (
    .clk (clk),
    .rst (rst),
    .req (req),
    .dec (dec_w)
  );

  // stage 2
  alu_execute u_execute (
    .clk (clk),
    .rst (rst),
    .dec (dec_w),
    .exe (exe_w)
  );

  // stage 3, response leaves three edges after the request
  flag_gen u_flags (
    .clk  (clk),
    .rst  (rst),
    .exe  (exe_w),
    .resp (resp)
  );

endmodule

`default_nettype wire

/* sim/alu_checker.sv */
// alu response monitor that checks values and latency against the pattern file
`timescale 1ns/10ps
`default_nettype none

module alu_checker
  import alu_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  alu_req_s  req,
  input  alu_resp_s resp,
  output logic      done,
  output int        errors
);

  localparam int MAX_VEC = 64;
  localparam int COLS    = 7;
  localparam int LATENCY = 3;

  logic [63:0] exp_mem [0:MAX_VEC*COLS-1];
  int          n_vec   = 0;
  int          checked = 0;
  int          passed  = 0;
  int          err_cnt = 0;
  int          cycle   = 0;
  int          req_cycles [$];  // edge numbers of requests in flight
  logic        fin     = 1'b0;

  assign done   = fin;
  assign errors = err_cnt;

  initial begin
    for (int k = 0; k < MAX_VEC*COLS; k++) exp_mem[k] = '0;
    $readmemh("sim/alu_patterns.hex", exp_mem);
    while (n_vec < MAX_VEC && exp_mem[n_vec*COLS] != '0) n_vec++;
  end

  always @(posedge clk) begin : compare
    int   idx;
    int   lat;
    logic bad;
    cycle = cycle + 1;
    if (!rst && req.valid === 1'b1) req_cycles.push_back(cycle);
    if (resp.valid === 1'b1) begin
      if (req_cycles.size() == 0 || checked >= n_vec) begin
        $display("unexpected response at %0t with no request in flight", $time);
        err_cnt++;
      end else begin
        idx = checked * COLS;
        bad = 1'b0;
        lat = cycle - req_cycles.pop_front();
        if (lat != LATENCY) begin
          $display("ERR %0t: vector %0d latency %0d cycles, expected %0d",
                   $time, checked, lat, LATENCY);
          bad = 1'b1;
        end
        if (resp.result !== exp_mem[idx+4]) begin
          $display("ERR %0t: vector %0d result %h, expected %h",
                   $time, checked, resp.result, exp_mem[idx+4]);
          bad = 1'b1;
        end
        // flag word only matters when it is written
        if (exp_mem[idx+6][0] && resp.flags !== exp_mem[idx+5][5:0]) begin
          $display("ERR %0t: vector %0d flags %b, expected %b",
                   $time, checked, resp.flags, exp_mem[idx+5][5:0]);
          bad = 1'b1;
        end
        if (resp.flags_we !== exp_mem[idx+6][0]) begin
          $display("ERR %0t: vector %0d flags_we %b, expected %b",
                   $time, checked, resp.flags_we, exp_mem[idx+6][0]);
          bad = 1'b1;
        end
        if (bad) err_cnt++;
        else passed++;
        $display("vector %0d op %03h %s", checked, exp_mem[idx][11:0], bad ? "fail" : "pass");
        checked++;
        if (checked == n_vec) begin
          $display("checked %0d vectors, %0d passed, %0d failed", checked, passed, err_cnt);
          fin <= 1'b1;
        end
      end
    end else if (resp.valid === 1'b0 && resp.flags_we !== 1'b0) begin
      // no flag write without a response
      $display("ERR %0t: flags_we %b with no valid response, expected 0",
               $time, resp.flags_we);
      err_cnt++;
    end
  end

endmodule

`default_nettype wire

/* sim/alu_tb.sv */
// alu pipeline testbench top with clock, reset, pattern stimulus and watchdog
`timescale 1ns/10ps
`default_nettype none

module alu_tb
  import alu_pkg::*;
();

  localparam int MAX_VEC = 64;
  localparam int COLS    = 7;  // op a b flags_in result flags flags_we
  localparam int BURST   = 8;  // last vectors go back to back

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  alu_req_s    req = '0;
  alu_resp_s   resp;
  logic        chk_done;
  int          chk_errors;
  int          n_vec = 0;
  logic [63:0] pat_mem [0:MAX_VEC*COLS-1];

  always #2 clk = ~clk;

  alu_top u_alu_top (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .resp (resp)
  );

  alu_checker u_checker (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .resp   (resp),
    .done   (chk_done),
    .errors (chk_errors)
  );

  function automatic alu_req_s build_req(input int idx);
    alu_req_s r;
    r          = '0;
    r.valid    = 1'b1;
    r.op       = pat_mem[idx*COLS][11:0];
    r.a        = pat_mem[idx*COLS+1];
    r.b        = pat_mem[idx*COLS+2];
    r.flags_in = pat_mem[idx*COLS+3][5:0];
    return r;
  endfunction

  initial begin : stimulus
    int idle;
    void'($urandom(32'hb802));
    for (int k = 0; k < MAX_VEC*COLS; k++) pat_mem[k] = '0;
    $readmemh("sim/alu_patterns.hex", pat_mem);
    while (n_vec < MAX_VEC && pat_mem[n_vec*COLS] != '0) n_vec++;  // opcode 0 ends the list
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_vec; i++) begin
      @(posedge clk);
      req <= build_req(i);
      idle = (i >= n_vec - BURST) ? 0 : int'($urandom % 4);
      repeat (idle) begin
        @(posedge clk);
        req.valid <= 1'b0;
      end
    end
    @(posedge clk);
    req.valid <= 1'b0;
  end

  initial begin : watchdog
    int limit;
    int cycles;
    cycles = 0;
    repeat (2) @(posedge clk);  // pattern count is known by now
    limit = n_vec * 8 + 50;
    while (!chk_done && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    @(negedge clk);
    if (!chk_done)
      $display("timeout: the run stopped after %0d cycles with responses still missing", cycles);
    if (chk_done && chk_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/alu_patterns.hex */
// columns: op a b flags_in exp_result exp_flags exp_flags_we
// op is {opcode, dst, src, spare} or {opcode, cond, spare}, flags are C O A S Z P
068 000000007fffffff 0000000000000001 00 0000000080000000 1d 1
068 12345678ffffffff 0000000000000001 00 0000000000000000 2b 1
07c 7fffffffffffffff 0000000000000001 00 8000000000000000 1d 1
07c 8000000000000000 8000000000000000 00 0000000000000000 33 1
07c 0000000000000123 0000000000000456 00 0000000000000579 00 1
0a8 0000000000000005 0000000000000007 00 00000000fffffffe 2c 1
0a8 deadbeef80000000 0000000000000001 00 000000007fffffff 19 1
0bc 0123456789abcdef 0123456789abcdef 00 0000000000000000 03 1
0bc 0000000000000000 0000000000000001 00 ffffffffffffffff 2d 1
0bc 8000000000000000 0000000000000001 00 7fffffffffffffff 19 1
0e8 fffffffff0f0f0f0 ffffffffff00ff00 00 00000000f000f000 05 1
0fc aaaaaaaaaaaaaaaa 5555555555555555 3f 0000000000000000 03 1
128 0000000000000001 0000000000000002 00 0000000000000003 01 1
13c 8000000000000000 0000000000000010 00 8000000000000010 04 1
168 1234567812345678 ffffffff12345678 3f 0000000000000000 03 1
17c 00000000000000ff ff00000000000001 00 ff000000000000fe 04 1
1a8 0000000000000000 0000000000000000 00 00000000ffffffff 05 1
1bc ffffffffffffffff 0000000000000000 00 0000000000000000 03 1
1fc 0000000000001111 fedcba9876543210 3f fedcba9876543210 00 0
230 0000000000000000 ffffffffffffff80 00 0000000000000080 00 0
230 0000000000000000 aaaaaaaaaaaaaa55 00 0000000000000055 00 0
234 0000000000000000 ffffffffffff8001 00 0000000000008001 00 0
238 0000000000000000 ffffffff80000000 00 0000000080000000 00 0
270 0000000000000000 0000000000000080 00 ffffffffffffff80 00 0
270 0000000000000000 ffffffffffffff7f 00 000000000000007f 00 0
274 0000000000000000 0000000000008001 00 ffffffffffff8001 00 0
274 0000000000000000 ffffffffffff7fff 00 0000000000007fff 00 0
278 0000000000000000 0000000080000000 00 ffffffff80000000 00 0
278 0000000000000000 ffffffff7fffffff 00 000000007fffffff 00 0
280 aaaaaaaaaaaaaaaa bbbbbbbbbbbbbbbb 02 bbbbbbbbbbbbbbbb 00 0
2c4 5555555555555555 6666666666666666 02 0000000000000000 00 0
288 aaaaaaaaaaaaaaaa bbbbbbbbbbbbbbbb 04 bbbbbbbbbbbbbbbb 00 0
2cc 5555555555555555 6666666666666666 00 0000000000000001 00 0
290 aaaaaaaaaaaaaaaa bbbbbbbbbbbbbbbb 00 bbbbbbbbbbbbbbbb 00 0
2d4 5555555555555555 6666666666666666 20 0000000000000001 00 0
298 aaaaaaaaaaaaaaaa bbbbbbbbbbbbbbbb 20 aaaaaaaaaaaaaaaa 00 0
2dc 5555555555555555 6666666666666666 20 0000000000000001 00 0
2a0 aaaaaaaaaaaaaaaa bbbbbbbbbbbbbbbb 14 bbbbbbbbbbbbbbbb 00 0
2e4 5555555555555555 6666666666666666 04 0000000000000001 00 0
2a8 aaaaaaaaaaaaaaaa bbbbbbbbbbbbbbbb 04 aaaaaaaaaaaaaaaa 00 0
2ec 5555555555555555 6666666666666666 10 0000000000000001 00 0
2b0 aaaaaaaaaaaaaaaa bbbbbbbbbbbbbbbb 00 aaaaaaaaaaaaaaaa 00 0
2f4 5555555555555555 6666666666666666 10 0000000000000000 00 0
2b8 aaaaaaaaaaaaaaaa bbbbbbbbbbbbbbbb 01 bbbbbbbbbbbbbbbb 00 0
2fc 5555555555555555 6666666666666666 01 0000000000000000 00 0
2d0 5555555555555555 6666666666666666 02 0000000000000000 00 0
2a0 aaaaaaaaaaaaaaaa bbbbbbbbbbbbbbbb 16 aaaaaaaaaaaaaaaa 00 0

/* compile.f */
+incdir+common
common/alu_pkg.sv
alu/cond_eval.sv
alu/alu_execute.sv
source/op_decode.sv
source/flag_gen.sv
source/alu_top.sv
sim/alu_checker.sv
sim/alu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= alu_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
